// ==== compile.f ====
logic/noc_tile_pkg.sv
logic/noc_flit_if.sv
logic/noc_flit_fifo.sv
logic/noc_rx_filter.sv
logic/ahb_mp_slave.sv
logic/noc_tile_top.sv
dv/noc_tile_tb.sv

// ==== Makefile ====
# Verilator simulation of the NoC tile endpoint

VERILATOR ?= verilator
TOP       ?= noc_tile_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/noc_tile_tb.sv ====
////////////////////////////////////////////////////////////
// NoC tile endpoint testbench
// Table-driven AHB and network traffic against tile 5
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module noc_tile_tb;
  import noc_tile_pkg::*;

  localparam int          CLK_PERIOD = 100;
  localparam int          RST_CYCLES = 8;
  localparam tile_id_t    MY_TILE    = 5'd5;
  localparam tile_id_t    SRC_TILE   = 5'd3;
  localparam logic [31:0] AHB_BASE   = 32'h4000_0000;
  localparam flit_t       FILL_BASE  = 32'hf111_0000;

  // One packet per row, word 0 fills the low header bits
  typedef struct packed {
    logic        is_send;
    tile_id_t    dest;
    logic [2:0]  len;
    flit_t [0:3] words;
  } pkt_row_t;

  localparam int NUM_ROWS = 8;
  localparam pkt_row_t ROWS [NUM_ROWS] = '{
    '{1'b1, 5'd2,  3'd3, {32'h0000_0a01, 32'hdead_0001, 32'hbeef_0002, 32'h0}},
    '{1'b0, 5'd5,  3'd2, {32'h0000_1b02, 32'h1111_2222, 32'h0, 32'h0}},
    '{1'b0, 5'd9,  3'd3, {32'h0000_2c03, 32'h3333_4444, 32'h5555_6666, 32'h0}},
    '{1'b0, 5'd5,  3'd4, {32'h0000_3d04, 32'h7777_8888, 32'h9999_aaaa, 32'hbbbb_cccc}},
    '{1'b1, 5'd7,  3'd1, {32'h0000_4e05, 32'h0, 32'h0, 32'h0}},
    '{1'b0, 5'd0,  3'd1, {32'h0000_5f06, 32'h0, 32'h0, 32'h0}},
    '{1'b0, 5'd5,  3'd1, {32'h0000_6007, 32'h0, 32'h0, 32'h0}},
    '{1'b1, 5'd31, 3'd4, {32'h0012_3456, 32'hcafe_f00d, 32'h0bad_cafe, 32'hffff_0000}}
  };

  // Fill test and empty read budgeted as two extra rows
  localparam int TIMEOUT_CYCLES = RST_CYCLES + 200 * (NUM_ROWS + 2);

  logic        clk;
  logic        rst_i;
  logic        hsel_i;
  logic [31:0] haddr_i;
  htrans_t     htrans_i;
  logic        hwrite_i;
  flit_t       hwdata_i;
  flit_t       hrdata_o;
  logic        hready_o;
  logic        hresp_o;
  flit_t       noc_in_flit_i;
  logic        noc_in_last_i;
  logic        noc_in_valid_i;
  logic        noc_in_ready_o;
  flit_t       noc_out_flit_o;
  logic        noc_out_last_o;
  logic        noc_out_valid_o;
  logic        noc_out_ready_i;

  // Network output capture
  flit_t     out_flits [$];
  logic      out_lasts [$];
  // 0 random stalls, 1 held low, 2 held high
  int        out_mode;
  drop_cnt_t drop_exp;

  noc_tile_top #(.TILE_ID(MY_TILE)) uut (
    .clk             (clk),
    .rst_i           (rst_i),
    .hsel_i          (hsel_i),
    .haddr_i         (haddr_i),
    .htrans_i        (htrans_i),
    .hwrite_i        (hwrite_i),
    .hwdata_i        (hwdata_i),
    .hrdata_o        (hrdata_o),
    .hready_o        (hready_o),
    .hresp_o         (hresp_o),
    .noc_in_flit_i   (noc_in_flit_i),
    .noc_in_last_i   (noc_in_last_i),
    .noc_in_valid_i  (noc_in_valid_i),
    .noc_in_ready_o  (noc_in_ready_o),
    .noc_out_flit_o  (noc_out_flit_o),
    .noc_out_last_o  (noc_out_last_o),
    .noc_out_valid_o (noc_out_valid_o),
    .noc_out_ready_i (noc_out_ready_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Output back-pressure
  always @(posedge clk) begin
    case (out_mode)
      0:       noc_out_ready_i <= (($urandom % 3) != 0);
      1:       noc_out_ready_i <= 1'b0;
      default: noc_out_ready_i <= 1'b1;
    endcase
  end

  // Flit seen here transfers at the next rising edge
  always @(negedge clk) begin
    if (!rst_i && noc_out_valid_o && noc_out_ready_i) begin
      out_flits.push_back(noc_out_flit_o);
      out_lasts.push_back(noc_out_last_o);
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Header carries dest and source over the low bits of word 0
  function automatic flit_t pkt_flit(input pkt_row_t row, input int idx);
    if (idx == 0) begin
      pkt_flit = {row.dest, SRC_TILE, row.words[0][21:0]};
    end else begin
      pkt_flit = row.words[idx];
    end
  endfunction

  // Single AHB transfer, address phase then data phase with wait states
  task automatic ahb_xfer(input logic is_write, input reg_off_t off, input flit_t wdata,
                          output flit_t rdata, output int waits);
    waits = 0;
    @(posedge clk);
    hsel_i   <= 1'b1;
    haddr_i  <= AHB_BASE | 32'(off);
    htrans_i <= NONSEQ;
    hwrite_i <= is_write;
    @(posedge clk);
    hsel_i   <= 1'b0;
    htrans_i <= IDLE;
    hwrite_i <= 1'b0;
    hwdata_i <= wdata;
    @(negedge clk);
    while (!hready_o) begin
      waits++;
      @(negedge clk);
    end
    rdata = hrdata_o;
    check_value("hresp_o", 32'h0, hresp_o);
  endtask

  task automatic check_status(input count_t rx_cnt, input logic head_last);
    flit_t rd;
    int    waits;
    ahb_xfer(1'b0, REG_STATUS, '0, rd, waits);
    check_value("status.rx_count", rx_cnt, rd[3:0]);
    check_value("status.tx_count", 32'h0, rd[7:4]);
    check_value("status.head_last", head_last, rd[8]);
    check_value("status.drop_count", drop_exp, rd[23:16]);
  endtask

  // Empty RX reads zero and pops nothing
  task automatic check_empty_recv();
    flit_t rd;
    int    waits;
    ahb_xfer(1'b0, REG_RECV, '0, rd, waits);
    check_value("hrdata_o", 32'h0, rd);
    check_status(4'd0, 1'b0);
  endtask

  task automatic expect_out(input flit_t flit, input logic last);
    while (out_flits.size() == 0) @(negedge clk);
    check_value("noc_out_flit_o", flit, out_flits.pop_front());
    check_value("noc_out_last_o", last, out_lasts.pop_front());
  endtask

  ////////////////////////////////////////////////////////////
  // Row handlers
  ////////////////////////////////////////////////////////////
  task automatic run_send(input pkt_row_t row);
    flit_t rd;
    int    waits;
    out_mode = 0;
    for (int i = 0; i < row.len; i++) begin
      ahb_xfer(1'b1, (i == row.len - 1) ? REG_SEND_LAST : REG_SEND,
               pkt_flit(row, i), rd, waits);
    end
    for (int i = 0; i < row.len; i++) begin
      expect_out(pkt_flit(row, i), i == row.len - 1);
    end
  endtask

  task automatic run_recv(input pkt_row_t row);
    flit_t rd;
    int    waits;
    int    gap;
    for (int i = 0; i < row.len; i++) begin
      gap = $urandom % 3;
      repeat (gap) @(posedge clk);
      @(posedge clk);
      noc_in_flit_i  <= pkt_flit(row, i);
      noc_in_last_i  <= (i == row.len - 1);
      noc_in_valid_i <= 1'b1;
      @(negedge clk);
      // Dropping, or the RX FIFO holds at most one packet here
      check_value("noc_in_ready_o", 32'h1, noc_in_ready_o);
      @(posedge clk);
      noc_in_valid_i <= 1'b0;
    end
    if (row.dest != MY_TILE) begin
      drop_exp = drop_exp + 1'b1;
      check_empty_recv();
    end else begin
      for (int i = 0; i < row.len; i++) begin
        check_status(count_t'(row.len - i), i == row.len - 1);
        ahb_xfer(1'b0, REG_RECV, '0, rd, waits);
        check_value("hrdata_o", pkt_flit(row, i), rd);
      end
      check_status(4'd0, 1'b0);
    end
  endtask

  // Fifth write stalls on a full TX FIFO until the output opens
  task automatic run_fill();
    flit_t rd;
    int    waits;
    out_mode = 1;
    for (int i = 0; i < 4; i++) begin
      ahb_xfer(1'b1, REG_SEND, FILL_BASE + i, rd, waits);
      check_value("fill.wait_states", 32'h0, waits);
    end
    fork
      ahb_xfer(1'b1, REG_SEND_LAST, FILL_BASE + 4, rd, waits);
      begin
        repeat (6) @(posedge clk);
        @(negedge clk);
        check_value("hready_o", 32'h0, hready_o);
        out_mode = 2;
      end
    join
    for (int i = 0; i < 5; i++) begin
      expect_out(FILL_BASE + i, i == 4);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(4910));
    clk             = 1'b0;
    rst_i           = 1'b1;
    hsel_i          = 1'b0;
    haddr_i         = '0;
    htrans_i        = IDLE;
    hwrite_i        = 1'b0;
    hwdata_i        = '0;
    noc_in_flit_i   = '0;
    noc_in_last_i   = 1'b0;
    noc_in_valid_i  = 1'b0;
    noc_out_ready_i = 1'b0;
    out_mode        = 2;
    drop_exp        = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    check_value("noc_out_valid_o", 32'h0, noc_out_valid_o);
    check_value("hready_o", 32'h1, hready_o);
    check_status(4'd0, 1'b0);
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (ROWS[r].is_send) begin
        run_send(ROWS[r]);
      end else begin
        run_recv(ROWS[r]);
      end
    end
    run_fill();
    check_empty_recv();
    $display("*** TEST PASSED ***");
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== logic/noc_tile_top.sv ====
////////////////////////////////////////////////////////////
// NoC tile endpoint top
// Joins the AHB-Lite slave and one network channel
// through the send and receive FIFOs and the filter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module noc_tile_top #(
  parameter noc_tile_pkg::tile_id_t TILE_ID = 5'd0
) (
  input  logic                  clk,
  input  logic                  rst_i,
  // AHB-Lite slave port
  input  logic                  hsel_i,
  input  logic [31:0]           haddr_i,
  input  noc_tile_pkg::htrans_t htrans_i,
  input  logic                  hwrite_i,
  input  noc_tile_pkg::flit_t   hwdata_i,
  output noc_tile_pkg::flit_t   hrdata_o,
  output logic                  hready_o,
  output logic                  hresp_o,
  // Network input
  input  noc_tile_pkg::flit_t   noc_in_flit_i,
  input  logic                  noc_in_last_i,
  input  logic                  noc_in_valid_i,
  output logic                  noc_in_ready_o,
  // Network output
  output noc_tile_pkg::flit_t   noc_out_flit_o,
  output logic                  noc_out_last_o,
  output logic                  noc_out_valid_o,
  input  logic                  noc_out_ready_i
);
  import noc_tile_pkg::*;

  // Internal flit channels
  noc_flit_if tx_push ();
  noc_flit_if rx_pass ();
  noc_flit_if rx_pop  ();
  noc_flit_if noc_out ();

  count_t    tx_count;
  count_t    rx_count;
  drop_cnt_t drop_cnt;

  // Network output straight from the TX FIFO head
  assign noc_out_flit_o  = noc_out.flit;
  assign noc_out_last_o  = noc_out.last;
  assign noc_out_valid_o = noc_out.valid;
  assign noc_out.ready   = noc_out_ready_i;

  ////////////////////////////////////////////////////////////
  // Register front end
  ////////////////////////////////////////////////////////////
  ahb_mp_slave u_ahb (
    .clk        (clk),
    .rst_i      (rst_i),
    .hsel_i     (hsel_i),
    .haddr_i    (haddr_i),
    .htrans_i   (htrans_i),
    .hwrite_i   (hwrite_i),
    .hwdata_i   (hwdata_i),
    .hrdata_o   (hrdata_o),
    .hready_o   (hready_o),
    .hresp_o    (hresp_o),
    .tx_if      (tx_push.src),
    .rx_if      (rx_pop.snk),
    .tx_count_i (tx_count),
    .rx_count_i (rx_count),
    .drop_cnt_i (drop_cnt)
  );

  // Send path
  noc_flit_fifo #(.DEPTH(TX_DEPTH)) u_tx_fifo (
    .clk     (clk),
    .rst_i   (rst_i),
    .wr_if   (tx_push.snk),
    .rd_if   (noc_out.src),
    .count_o (tx_count)
  );

  ////////////////////////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////////////////////////
  noc_rx_filter u_filter (
    .clk        (clk),
    .rst_i      (rst_i),
    .tile_id_i  (TILE_ID),
    .in_flit_i  (noc_in_flit_i),
    .in_last_i  (noc_in_last_i),
    .in_valid_i (noc_in_valid_i),
    .in_ready_o (noc_in_ready_o),
    .out_if     (rx_pass.src),
    .drop_cnt_o (drop_cnt)
  );

  noc_flit_fifo #(.DEPTH(RX_DEPTH)) u_rx_fifo (
    .clk     (clk),
    .rst_i   (rst_i),
    .wr_if   (rx_pass.snk),
    .rd_if   (rx_pop.src),
    .count_o (rx_count)
  );

endmodule

// ==== logic/ahb_mp_slave.sv ====
////////////////////////////////////////////////////////////
// AHB-Lite message-passing slave
// Send and receive registers in front of the flit FIFOs
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_mp_slave (
  input  logic                    clk,
  input  logic                    rst_i,
  // AHB-Lite slave port
  input  logic                    hsel_i,
  input  logic [31:0]             haddr_i,
  input  noc_tile_pkg::htrans_t   htrans_i,
  input  logic                    hwrite_i,
  input  noc_tile_pkg::flit_t     hwdata_i,
  output noc_tile_pkg::flit_t     hrdata_o,
  output logic                    hready_o,
  output logic                    hresp_o,
  // FIFO sides
  noc_flit_if.src                 tx_if,
  noc_flit_if.snk                 rx_if,
  input  noc_tile_pkg::count_t    tx_count_i,
  input  noc_tile_pkg::count_t    rx_count_i,
  input  noc_tile_pkg::drop_cnt_t drop_cnt_i
);
  import noc_tile_pkg::*;

  // Data phase state captured from the address phase
  logic     dp_valid_q;
  logic     dp_write_q;
  reg_off_t dp_off_q;

  logic  addr_valid;
  logic  wr_send;
  logic  rd_recv;
  logic  rd_status;
  flit_t status_word;

  ////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////

  // Only NONSEQ and SEQ carry a transfer, bursts act as singles
  assign addr_valid = hsel_i & ((htrans_i == NONSEQ) | (htrans_i == SEQ));

  // Sample only when the previous data phase completes
  always_ff @(posedge clk) begin
    if (rst_i) begin
      dp_valid_q <= 1'b0;
      dp_write_q <= 1'b0;
      dp_off_q   <= '0;
    end else if (hready_o) begin
      dp_valid_q <= addr_valid;
      dp_write_q <= hwrite_i;
      dp_off_q   <= haddr_i[3:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Data phase decode
  ////////////////////////////////////////////////////////////
  assign wr_send   = dp_valid_q & dp_write_q &
                     ((dp_off_q == REG_SEND) | (dp_off_q == REG_SEND_LAST));
  assign rd_recv   = dp_valid_q & ~dp_write_q & (dp_off_q == REG_RECV);
  assign rd_status = dp_valid_q & ~dp_write_q & (dp_off_q == REG_STATUS);

  // Send push, held until the TX FIFO takes it
  assign tx_if.valid = wr_send;
  assign tx_if.flit  = hwdata_i;
  assign tx_if.last  = (dp_off_q == REG_SEND_LAST);

  // Wait states only while the TX FIFO is full
  assign hready_o = ~(wr_send & ~tx_if.ready);
  // Always OKAY
  assign hresp_o  = 1'b0;

  // Pop the head in the same cycle it is returned
  assign rx_if.ready = rd_recv & rx_if.valid;

  // Status layout
  // [3:0] rx count, [7:4] tx count, [8] head last, [23:16] drops
  assign status_word = {8'h00, drop_cnt_i, 7'h00, rx_if.valid & rx_if.last,
                        tx_count_i, rx_count_i};

  // Read data mux, empty RX reads as zero
  always_comb begin
    hrdata_o = '0;
    if (rd_recv && rx_if.valid) begin
      hrdata_o = rx_if.flit;
    end else if (rd_status) begin
      hrdata_o = status_word;
    end
  end

endmodule

// ==== logic/noc_rx_filter.sv ====
////////////////////////////////////////////////////////////
// Receive filter
// Passes packets addressed to this tile, drops the rest
// and counts each dropped packet
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module noc_rx_filter (
  input  logic                    clk,
  input  logic                    rst_i,
  input  noc_tile_pkg::tile_id_t  tile_id_i,
  input  noc_tile_pkg::flit_t     in_flit_i,
  input  logic                    in_last_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  noc_flit_if.src                 out_if,
  output noc_tile_pkg::drop_cnt_t drop_cnt_o
);
  import noc_tile_pkg::*;

  typedef enum logic [1:0] {WAIT_HDR, PASS, DROP} state_t;

  state_t    state_q;
  drop_cnt_t drop_cnt_q;
  tile_id_t  hdr_dest;
  logic      hdr_match;
  logic      fwd;
  logic      xfer;

  // Header destination check, only meaningful in WAIT_HDR
  assign hdr_dest  = in_flit_i[HDR_DEST_MSB:HDR_DEST_LSB];
  assign hdr_match = (hdr_dest == tile_id_i);

  // Forwarding path for the current flit
  assign fwd = (state_q == PASS) | ((state_q == WAIT_HDR) & hdr_match);

  assign out_if.flit  = in_flit_i;
  assign out_if.last  = in_last_i;
  assign out_if.valid = in_valid_i & fwd;
  // Dropped flits are always accepted
  assign in_ready_o   = fwd ? out_if.ready : 1'b1;
  assign xfer         = in_valid_i & in_ready_o;
  assign drop_cnt_o   = drop_cnt_q;

  ////////////////////////////////////////////////////////////
  // Packet FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= WAIT_HDR;
      drop_cnt_q <= '0;
    end else if (xfer) begin
      case (state_q)
        WAIT_HDR: begin
          if (!hdr_match) begin
            drop_cnt_q <= drop_cnt_q + 1'b1;
          end
          // Single flit packet stays waiting for the next header
          if (!in_last_i) begin
            state_q <= hdr_match ? PASS : DROP;
          end
        end
        default: begin
          if (in_last_i) begin
            state_q <= WAIT_HDR;
          end
        end
      endcase
    end
  end

endmodule

// ==== logic/noc_flit_fifo.sv ====
////////////////////////////////////////////////////////////
// Flit FIFO
// Synchronous circular buffer of flits and last bits
// with simultaneous push and pop and a fill count
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module noc_flit_fifo #(
  parameter int DEPTH = noc_tile_pkg::TX_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_i,
  noc_flit_if.snk               wr_if,
  noc_flit_if.src               rd_if,
  output noc_tile_pkg::count_t  count_o
);
  import noc_tile_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  typedef logic [AW-1:0] ptr_t;

  // Storage, no reset needed
  flit_t mem_flit [DEPTH];
  logic  mem_last [DEPTH];

  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  count_t count_q;

  logic push;
  logic pop;

  // Handshake flags
  assign wr_if.ready = (count_q != count_t'(DEPTH));
  assign rd_if.valid = (count_q != '0);
  assign push        = wr_if.valid & wr_if.ready;
  assign pop         = rd_if.valid & rd_if.ready;

  // Head entry
  assign rd_if.flit = mem_flit[rd_ptr_q];
  assign rd_if.last = mem_last[rd_ptr_q];
  assign count_o    = count_q;

  ////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Write port
  always_ff @(posedge clk) begin
    if (push) begin
      mem_flit[wr_ptr_q] <= wr_if.flit;
      mem_last[wr_ptr_q] <= wr_if.last;
    end
  end

endmodule

// ==== logic/noc_flit_if.sv ====
////////////////////////////////////////////////////////////
// Flit channel bundle
// Flit, last, valid and ready with source and sink views
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface noc_flit_if;
  import noc_tile_pkg::*;

  // Payload and framing
  flit_t flit;
  logic  last;
  // Handshake, transfer when both high on clk
  logic  valid;
  logic  ready;

  // Producer side
  modport src (
    output flit, last, valid,
    input  ready
  );

  // Consumer side
  modport snk (
    input  flit, last, valid,
    output ready
  );

endinterface

// ==== logic/noc_tile_pkg.sv ====
////////////////////////////////////////////////////////////
// NoC tile endpoint package
// Flit and header types, register map and FIFO sizing
// shared by the message-passing endpoint
////////////////////////////////////////////////////////////

package noc_tile_pkg;

  // Flit format
  localparam int FLIT_WIDTH = 32;
  typedef logic [FLIT_WIDTH-1:0] flit_t;

  // Tile address carried in the header flit
  typedef logic [4:0] tile_id_t;
  localparam int HDR_DEST_MSB = 31;
  localparam int HDR_DEST_LSB = 27;
  localparam int HDR_SRC_MSB  = 26;
  localparam int HDR_SRC_LSB  = 22;

  // Buffer depths
  localparam int TX_DEPTH = 4;
  localparam int RX_DEPTH = 8;

  // Fill count, holds 0..RX_DEPTH
  typedef logic [3:0] count_t;
  // Dropped packet counter, wraps
  typedef logic [7:0] drop_cnt_t;

  // Register offsets inside the slave window
  typedef logic [3:0] reg_off_t;
  localparam reg_off_t REG_SEND      = 4'h0;
  localparam reg_off_t REG_SEND_LAST = 4'h4;
  localparam reg_off_t REG_RECV      = 4'h8;
  localparam reg_off_t REG_STATUS    = 4'hC;

  // AHB transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

endpackage
